// File: fpAddSettings.svh
// Single-precision field widths, bias and pipeline depth shared by the adder RTL and testbench
`ifndef FP_ADD_SETTINGS_SVH
`define FP_ADD_SETTINGS_SVH

// IEEE-754 binary32 layout
`define FP_EXP_WIDTH 8                      // Biased exponent field
`define FP_MAN_WIDTH 23                     // Stored fraction, implicit one not included

// Exponent encodings
`define FP_EXP_BIAS 127                     // Bias of the exponent field
`define FP_EXP_MAX 255                      // All-ones exponent, infinity

// Cycles from inValid to resultValid
`define FP_ADD_LATENCY 3                    // Align, add, normalize/round

`endif

// File: fpAddPkg.sv
// Package with the binary32 field struct and raw/field union, referenced by scoped name
`include "fpAddSettings.svh"

package fpAddPkg;

    // Field view of one single-precision word
    typedef struct packed {
        logic                     sign;     // Sign, 1 means negative
        logic [`FP_EXP_WIDTH-1:0] exponent; // Biased exponent
        logic [`FP_MAN_WIDTH-1:0] fraction; // Fraction bits below the implicit one
    } fpFields;

    // Same 32 bits seen as a raw word or as decoded fields
    typedef union packed {
        logic [`FP_EXP_WIDTH+`FP_MAN_WIDTH:0] raw; // Raw bits as carried on the top level
        fpFields                              fields; // Decoded view used inside the stages
    } fpWord;

endpackage

// File: Alignment.sv
// Pipeline stage 1: unpack both operands, order them by magnitude and align the smaller mantissa
`timescale 1ns/100ps
`include "fpAddSettings.svh"

module Alignment
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     inValid,
    input  fpAddPkg::fpWord          operandA,
    input  fpAddPkg::fpWord          operandB,
    output logic                     alignValid,
    output logic [`FP_MAN_WIDTH:0]   largeMantissa,
    output logic [`FP_MAN_WIDTH:0]   smallMantissa,
    output logic                     guardBit,
    output logic                     roundBit,
    output logic                     stickyBit,
    output logic [`FP_EXP_WIDTH-1:0] alignExponent,
    output logic                     resultSign,
    output logic                     effectiveSubtract
);

fpAddPkg::fpWord            largeOperand, smallOperand;     // Operands after magnitude ordering
logic                       aIsLarge;                       // A has the larger magnitude
logic [`FP_EXP_WIDTH-1:0]   exponentDifferential;           // Right shift for the small operand
logic [`FP_MAN_WIDTH+2:0]   extendedSmall;                  // Implicit one, fraction, two zero bits
logic [`FP_MAN_WIDTH+2:0]   shiftedSmall;                   // Mantissa, guard and round after shift
logic                       lostBits;                       // OR of everything shifted past round

always_comb
begin
    // Exponent and fraction are adjacent, so one compare orders by magnitude
    aIsLarge = {operandA.fields.exponent, operandA.fields.fraction} >=
               {operandB.fields.exponent, operandB.fields.fraction};
    largeOperand = aIsLarge ? operandA : operandB;          // Larger magnitude keeps its place
    smallOperand = aIsLarge ? operandB : operandA;          // Smaller one gets shifted

    exponentDifferential = largeOperand.fields.exponent - smallOperand.fields.exponent;
    extendedSmall = {1'b1, smallOperand.fields.fraction, 2'b00}; // Add implicit one, room for G and R
    shiftedSmall = extendedSmall >> exponentDifferential;   // Line up with the large operand

    if (exponentDifferential > (`FP_MAN_WIDTH + 3))
        lostBits = |extendedSmall;                          // Whole mantissa falls past round
    else
        lostBits = |(extendedSmall << ((`FP_MAN_WIDTH + 3) - exponentDifferential)); // Low bits only
end

always_ff @(posedge clock)
begin
    if (reset)
        alignValid <= 1'b0;                                 // Pipeline empty after reset
    else
        alignValid <= inValid;                              // Strobe follows the data by one cycle
end

always_ff @(posedge clock)
begin
    if (inValid)
    begin
        largeMantissa     <= {1'b1, largeOperand.fields.fraction}; // Large operand with implicit one
        smallMantissa     <= shiftedSmall[`FP_MAN_WIDTH+2:2];      // Top 24 bits after the shift
        guardBit          <= shiftedSmall[1];                      // First bit below the mantissa
        roundBit          <= shiftedSmall[0];                      // Second bit below
        stickyBit         <= lostBits;
        alignExponent     <= largeOperand.fields.exponent;         // Common exponent after alignment
        resultSign        <= largeOperand.fields.sign;             // Larger magnitude sets the sign
        effectiveSubtract <= operandA.fields.sign ^ operandB.fields.sign; // Signs differ, so subtract
    end
end

// With equal exponents the ordering alone must keep large above small
zeroShiftOrdered: assert property (@(posedge clock) disable iff (reset)
    inValid && (exponentDifferential == '0) |=> largeMantissa >= smallMantissa);

endmodule

// File: MantissaAddSub.sv
// Pipeline stage 2: add or subtract the aligned mantissas and register the wide sum
`timescale 1ns/100ps
`include "fpAddSettings.svh"

module MantissaAddSub
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     alignValid,
    input  logic [`FP_MAN_WIDTH:0]   largeMantissa,
    input  logic [`FP_MAN_WIDTH:0]   smallMantissa,
    input  logic                     guardBit,
    input  logic                     roundBit,
    input  logic                     stickyBit,
    input  logic [`FP_EXP_WIDTH-1:0] alignExponent,
    input  logic                     resultSign,
    input  logic                     effectiveSubtract,
    output logic                     sumValid,
    output logic [`FP_MAN_WIDTH+4:0] sumMantissa,
    output logic [`FP_EXP_WIDTH-1:0] sumExponent,
    output logic                     sumSign
);

logic [`FP_MAN_WIDTH+4:0] largeExtended;                    // Carry slot, mantissa, three zero bits
logic [`FP_MAN_WIDTH+4:0] smallExtended;                    // Carry slot, mantissa, G, R, S
logic [`FP_MAN_WIDTH+4:0] rawSum;

always_comb
begin
    largeExtended = {1'b0, largeMantissa, 3'b000};
    smallExtended = {1'b0, smallMantissa, guardBit, roundBit, stickyBit};
    if (effectiveSubtract)
        rawSum = largeExtended - smallExtended;             // Ordered by magnitude, never negative
    else
        rawSum = largeExtended + smallExtended;             // May set the carry bit
end

always_ff @(posedge clock)
begin
    if (reset)
        sumValid <= 1'b0;
    else
        sumValid <= alignValid;
end

always_ff @(posedge clock)
begin
    if (alignValid)
    begin
        sumMantissa <= rawSum;
        sumExponent <= alignExponent;                       // Exponent rides along unchanged
        sumSign     <= resultSign;
    end
end

// Stage 1 ordering guarantees a difference without a borrow into the carry slot
subtractNoCarry: assert property (@(posedge clock) disable iff (reset)
    alignValid && effectiveSubtract |=> !sumMantissa[`FP_MAN_WIDTH+4]);

endmodule

// File: NormalizeRound.sv
// Pipeline stage 3: normalize the sum, round to nearest even and pack the binary32 result
`timescale 1ns/100ps
`include "fpAddSettings.svh"

module NormalizeRound
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     sumValid,
    input  logic [`FP_MAN_WIDTH+4:0] sumMantissa,
    input  logic [`FP_EXP_WIDTH-1:0] sumExponent,
    input  logic                     sumSign,
    output logic                     resultValid,
    output fpAddPkg::fpWord          result
);

logic                             carryOut;                 // Sum reached two or more
logic [4:0]                       leadZeros;                // Left shift when there is no carry
logic [`FP_MAN_WIDTH+3:0]         normMantissa;             // Leading one, fraction, G, R, S
logic signed [`FP_EXP_WIDTH+1:0]  normExponent;             // Wide so over and underflow show
logic                             roundUp;
logic [`FP_MAN_WIDTH+1:0]         roundedMantissa;          // Extra top bit catches rounding carry
logic signed [`FP_EXP_WIDTH+1:0]  finalExponent;
fpAddPkg::fpWord                  packedResult;

// Leading-zero count below the carry bit, highest set bit wins
always_comb
begin
    leadZeros = '0;
    for (int i = 0; i <= `FP_MAN_WIDTH + 3; i++)
    begin
        if (sumMantissa[i])
            leadZeros = 5'((`FP_MAN_WIDTH + 3) - i);
    end
end

always_comb
begin
    carryOut = sumMantissa[`FP_MAN_WIDTH+4];

    if (carryOut)
    begin
        // Shift right one, folding the dropped bit into sticky
        normMantissa = {sumMantissa[`FP_MAN_WIDTH+4:2], sumMantissa[1] | sumMantissa[0]};
        normExponent = $signed({2'b00, sumExponent}) + 10'sd1;
    end
    else
    begin
        normMantissa = sumMantissa[`FP_MAN_WIDTH+3:0] << leadZeros; // Bring the leading one to the top
        normExponent = $signed({2'b00, sumExponent}) - $signed({5'd0, leadZeros});
    end

    // Nearest even: guard decides, round|sticky or an odd LSB breaks the tie
    roundUp = normMantissa[2] & (normMantissa[1] | normMantissa[0] | normMantissa[3]);
    roundedMantissa = {1'b0, normMantissa[`FP_MAN_WIDTH+3:3]} + {{(`FP_MAN_WIDTH+1){1'b0}}, roundUp};
    finalExponent = normExponent + $signed({9'd0, roundedMantissa[`FP_MAN_WIDTH+1]}); // Rounding carry

    packedResult.fields.sign = sumSign;
    packedResult.fields.exponent = finalExponent[`FP_EXP_WIDTH-1:0];
    packedResult.fields.fraction = roundedMantissa[`FP_MAN_WIDTH-1:0]; // Zero after a rounding carry

    if ((sumMantissa == '0) || (finalExponent <= 0))
        packedResult.raw = '0;                              // Exact cancel or underflow, positive zero
    else if (finalExponent >= `FP_EXP_MAX)
    begin
        packedResult.fields.exponent = '1;                  // Overflow to signed infinity
        packedResult.fields.fraction = '0;
    end
end

always_ff @(posedge clock)
begin
    if (reset)
        resultValid <= 1'b0;
    else
        resultValid <= sumValid;
end

always_ff @(posedge clock)
begin
    if (sumValid)
        result <= packedResult;
end

// No NaN encodings may leave the adder
noNanOut: assert property (@(posedge clock) disable iff (reset)
    sumValid |=> (result.fields.exponent != '1) || (result.fields.fraction == '0));

endmodule

// File: FpAdder.sv
// Top level of the three-stage binary32 adder, chaining align, add/sub and normalize/round stages
`timescale 1ns/100ps
`include "fpAddSettings.svh"

module FpAdder
(
    input  logic            clock,
    input  logic            reset,
    input  logic            inValid,
    input  fpAddPkg::fpWord operandA,
    input  fpAddPkg::fpWord operandB,
    output logic            resultValid,
    output fpAddPkg::fpWord result
);

// Stage 1 to stage 2
logic                     alignValid;
logic [`FP_MAN_WIDTH:0]   largeMantissa;                    // With implicit one
logic [`FP_MAN_WIDTH:0]   smallMantissa;                    // Shifted into alignment
logic                     guardBit;
logic                     roundBit;
logic                     stickyBit;
logic [`FP_EXP_WIDTH-1:0] alignExponent;
logic                     resultSign;
logic                     effectiveSubtract;

// Stage 2 to stage 3
logic                     sumValid;
logic [`FP_MAN_WIDTH+4:0] sumMantissa;                      // Carry, mantissa, G, R, S
logic [`FP_EXP_WIDTH-1:0] sumExponent;
logic                     sumSign;

Alignment alignStage (
    .clock             (clock),
    .reset             (reset),
    .inValid           (inValid),
    .operandA          (operandA),
    .operandB          (operandB),
    .alignValid        (alignValid),
    .largeMantissa     (largeMantissa),
    .smallMantissa     (smallMantissa),
    .guardBit          (guardBit),
    .roundBit          (roundBit),
    .stickyBit         (stickyBit),
    .alignExponent     (alignExponent),
    .resultSign        (resultSign),
    .effectiveSubtract (effectiveSubtract)
);

MantissaAddSub addStage (
    .clock             (clock),
    .reset             (reset),
    .alignValid        (alignValid),
    .largeMantissa     (largeMantissa),
    .smallMantissa     (smallMantissa),
    .guardBit          (guardBit),
    .roundBit          (roundBit),
    .stickyBit         (stickyBit),
    .alignExponent     (alignExponent),
    .resultSign        (resultSign),
    .effectiveSubtract (effectiveSubtract),
    .sumValid          (sumValid),
    .sumMantissa       (sumMantissa),
    .sumExponent       (sumExponent),
    .sumSign           (sumSign)
);

NormalizeRound roundStage (
    .clock       (clock),
    .reset       (reset),
    .sumValid    (sumValid),
    .sumMantissa (sumMantissa),
    .sumExponent (sumExponent),
    .sumSign     (sumSign),
    .resultValid (resultValid),
    .result      (result)
);

endmodule

// File: FpAdderTb.sv
// Self-checking testbench for the pipelined binary32 adder, run as the simulation top module
`timescale 1ns/100ps
`include "fpAddSettings.svh"

module FpAdderTb;

localparam int vectorCount   = 3000;                        // Operand pairs sent to the DUT
localparam int clockPeriod   = 4;                           // ns
localparam int timeoutCycles = vectorCount * 2 + 100;       // Generous bound on run length

logic            clock;
logic            reset;
logic            inValid;
fpAddPkg::fpWord operandA;
fpAddPkg::fpWord operandB;
logic            resultValid;
fpAddPkg::fpWord result;

logic [31:0] expectQueue[$];                                // Model results in input order
int          stampQueue[$];                                 // Cycle at which each pair was taken
int          cycleCount     = 0;
int          sentCount      = 0;
int          receivedCount  = 0;
int          valueErrors    = 0;
int          protocolErrors = 0;

FpAdder DUT (
    .clock       (clock),
    .reset       (reset),
    .inValid     (inValid),
    .operandA    (operandA),
    .operandB    (operandB),
    .resultValid (resultValid),
    .result      (result)
);

// Exact sum on a wide integer grid, rounded once to nearest even
function automatic logic [31:0] expectedSum(input logic [31:0] a, input logic [31:0] b);
    logic [299:0] magA;
    logic [299:0] magB;
    logic [299:0] magSum;
    logic [299:0] keep;
    logic [299:0] rest;
    logic [299:0] half;
    logic         sumSign;
    int           expA;
    int           expB;
    int           expMin;
    int           msb;
    int           shift;
    int           resultExp;
    expA = int'(a[30:23]);
    expB = int'(b[30:23]);
    expMin = (expA < expB) ? expA : expB;                   // Grid step is the smaller exponent
    magA = {276'd0, 1'b1, a[`FP_MAN_WIDTH-1:0]};
    magB = {276'd0, 1'b1, b[`FP_MAN_WIDTH-1:0]};
    magA = magA << (expA - expMin);                         // 300 bits hold every shifted bit
    magB = magB << (expB - expMin);
    if (a[31] == b[31])
    begin
        magSum = magA + magB;
        sumSign = a[31];
    end
    else if (magA >= magB)
    begin
        magSum = magA - magB;
        sumSign = a[31];
    end
    else
    begin
        magSum = magB - magA;
        sumSign = b[31];
    end
    if (magSum == '0)
        return 32'd0;                                       // Exact cancel gives positive zero
    msb = 0;
    for (int i = 0; i < 300; i++)
        if (magSum[i])
            msb = i;
    resultExp = expMin + msb - `FP_MAN_WIDTH;               // Leading one at bit 23 keeps expMin
    if (msb > `FP_MAN_WIDTH)
    begin
        shift = msb - `FP_MAN_WIDTH;
        keep = magSum >> shift;
        rest = magSum - (keep << shift);                    // Discarded part
        half = 300'd1 << (shift - 1);
        if ((rest > half) || ((rest == half) && keep[0]))
            keep = keep + 300'd1;                           // Nearest, ties to even
        if (keep[`FP_MAN_WIDTH+1])
        begin
            keep = keep >> 1;                               // Rounding carried into a new bit
            resultExp++;
        end
    end
    else
        keep = magSum << (`FP_MAN_WIDTH - msb);             // Exact left shift
    if (resultExp >= `FP_EXP_MAX)
        return {sumSign, 8'(`FP_EXP_MAX), 23'd0};           // Signed infinity
    if (resultExp <= 0)
        return 32'd0;                                       // Flush to positive zero
    return {sumSign, 8'(resultExp), keep[`FP_MAN_WIDTH-1:0]};
endfunction

// One random pair of normal operands, some steered toward corner cases
task automatic makeOperands(output logic [31:0] a, output logic [31:0] b);
    int          mode;
    int          expA;
    int          expB;
    int          swap;
    logic        signA;
    logic        signB;
    logic [22:0] fracA;
    logic [22:0] fracB;
    mode  = int'($urandom_range(7, 0));
    expA  = int'($urandom_range(254, 1));
    expB  = int'($urandom_range(254, 1));
    signA = 1'($urandom_range(1, 0));
    signB = 1'($urandom_range(1, 0));
    fracA = 23'($urandom());
    fracB = 23'($urandom());
    case (mode)
        3:
        begin
            expB = expA;                                    // Equal exponents, opposite signs
            signB = ~signA;
            if ($urandom_range(3, 0) == 0)
                fracB = fracA;                              // Exact negation
        end
        4:
        begin
            expA = int'($urandom_range(254, 28));
            expB = expA - int'($urandom_range(expA - 1, 27)); // Difference above 26
            if ($urandom_range(1, 0) == 1)
            begin
                swap = expA;
                expA = expB;
                expB = swap;
            end
        end
        5:
        begin
            expA = int'($urandom_range(254, 250));          // Near the top so the sum may overflow
            expB = int'($urandom_range(254, 250));
            signB = signA;
        end
        6:
        begin
            expB = (expA > 1) ? expA - int'($urandom_range(1, 0)) : expA;
            signB = ~signA;
            fracB = fracA ^ 23'($urandom_range(255, 0));    // Heavy cancellation
        end
        7:
            signB = signA;                                  // Plain same-sign add
        default:
            ;
    endcase
    a = {signA, 8'(expA), fracA};
    b = {signB, 8'(expB), fracB};
endtask

initial
begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
end

// Watchdog
initial
begin
    #(timeoutCycles * clockPeriod);
    $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("Test failures found");
    $finish;
end

// Scoreboard sees the values the DUT samples on this edge
always @(posedge clock)
begin
    logic [31:0] expected;
    int          stamp;
    if (!reset)
    begin
        cycleCount++;
        if (resultValid)
        begin
            receivedCount++;
            assert (expectQueue.size() > 0)
            else
            begin
                protocolErrors++;
                $display("resultValid came with no operation in flight at cycle %0d", cycleCount);
            end
            if (expectQueue.size() > 0)
            begin
                expected = expectQueue.pop_front();
                stamp = stampQueue.pop_front();
                assert (result.raw == expected)
                else
                begin
                    valueErrors++;
                    $display("error: result = 0x%08h, expected 0x%08h", result.raw, expected);
                end
                assert (cycleCount - stamp == `FP_ADD_LATENCY)
                else
                begin
                    protocolErrors++;
                    $display("Result came %0d cycles after its input, not the fixed latency",
                             cycleCount - stamp);
                end
            end
        end
        if (inValid)
        begin
            sentCount++;
            expectQueue.push_back(expectedSum(operandA.raw, operandB.raw));
            stampQueue.push_back(cycleCount);
        end
    end
end

// Stimulus and final report
initial
begin
    logic [31:0] a;
    logic [31:0] b;
    int          issued;
    void'($urandom(49888));                                 // Seed the random stream
    reset = 1'b1;
    inValid = 1'b0;
    operandA = '0;
    operandB = '0;
    issued = 0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    while (issued < vectorCount)
    begin
        @(posedge clock);
        makeOperands(a, b);
        operandA.raw <= a;
        operandB.raw <= b;
        if ($urandom_range(3, 0) != 0)                      // High about 3 cycles in 4
        begin
            inValid <= 1'b1;
            issued++;
        end
        else
            inValid <= 1'b0;
    end
    @(posedge clock);
    inValid <= 1'b0;
    @(posedge clock);
    while (expectQueue.size() != 0)
        @(posedge clock);                                   // Drain the pipeline
    repeat (`FP_ADD_LATENCY + 2) @(posedge clock);          // Room for a stray strobe
    assert (receivedCount == sentCount)
    else
    begin
        protocolErrors++;
        $display("Sent %0d operations but received %0d results", sentCount, receivedCount);
    end
    $display("Summary: %0d value errors, %0d protocol errors, %0d results checked",
             valueErrors, protocolErrors, receivedCount);
    if ((valueErrors == 0) && (protocolErrors == 0))
        $display("All tests passed!");
    else
        $display("Test failures found");
    $finish;
end

endmodule

// File: build.f
+incdir+.
fpAddPkg.sv
Alignment.sv
MantissaAddSub.sv
NormalizeRound.sv
FpAdder.sv
FpAdderTb.sv

// File: Makefile
# Verilator build and run of the pipelined binary32 adder testbench
VERILATOR ?= verilator
TOP       ?= FpAdderTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and pass if the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
